// ==== design/CorePkg.sv ====
`default_nettype none

package CorePkg;

    // ------------------------------
    // Widths and basic types
    // ------------------------------

    localparam int XLEN = 32;           // Data word width

    typedef logic [XLEN-1:0] Data;
    typedef logic [31:0]     InstAddr;  // Byte address of an instruction
    typedef logic [4:0]      GPRAddr;

    // ------------------------------
    // Encodings
    // ------------------------------

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } Opcode;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_COPY_B                      // LUI immediate passes straight through
    } AluOp;

    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} PcNextSel;
    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} OperandASel;
    typedef enum logic       {OPB_RS2, OPB_IMM} OperandBSel;
    typedef enum logic [1:0] {WR_ALU, WR_MEM, WR_PC_PLUS4} WrDataSel;

    // ------------------------------
    // Shared structs
    // ------------------------------

    typedef struct packed {
        GPRAddr     rs1;
        GPRAddr     rs2;
        GPRAddr     rd;
        logic [2:0] funct3;
        Data        imm;                // Sign extended for every format
    } DecodedInst;

    typedef struct packed {
        AluOp       aluOp;
        OperandASel opASel;
        OperandBSel opBSel;
        WrDataSel   wrDataSel;
        PcNextSel   pcNextSel;
        logic       regWe;
        logic       memWe;
        logic       memRe;
    } CtrlSignals;

    // Data bus request, core to data memory
    typedef struct packed {
        Data  addr;
        logic we;
        Data  wdata;
    } DataBusReq;

    // One retired instruction
    typedef struct packed {
        logic    valid;
        InstAddr pc;
        Data     inst;
        logic    regWe;
        GPRAddr  rd;
        Data     regData;
        logic    memWe;
        Data     memAddr;
        Data     memData;
    } RetireInfo;

endpackage

`default_nettype wire

// ==== design/InstDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module InstDecoder (
    input  CorePkg::Data        i_inst,  // Raw instruction word
    output CorePkg::DecodedInst o_dec);  // Register fields and immediate

    import CorePkg::*;

    Opcode opcode;

    assign opcode = Opcode'(i_inst[6:0]);

    always_comb begin
        o_dec.rs1    = i_inst[19:15];
        o_dec.rs2    = i_inst[24:20];
        o_dec.rd     = i_inst[11:7];
        o_dec.funct3 = i_inst[14:12];

        // Immediate format follows the opcode
        case (opcode)
            OPC_STORE:                   // S format
                o_dec.imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            OPC_BRANCH:                  // B format, bit 0 always zero
                o_dec.imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                             i_inst[30:25], i_inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:          // U format
                o_dec.imm = {i_inst[31:12], 12'b0};
            OPC_JAL:                     // J format
                o_dec.imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                             i_inst[20], i_inst[30:21], 1'b0};
            default:                     // I format for OP_IMM, LOAD, JALR
                o_dec.imm = {{20{i_inst[31]}}, i_inst[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== design/DatapathController.sv ====
`timescale 1ns/1ps
`default_nettype none

module DatapathController (
    input  CorePkg::Data        i_inst,  // Raw instruction word
    output CorePkg::CtrlSignals o_ctrl); // Control word for the datapath

    import CorePkg::*;

    Opcode      opcode;
    logic [2:0] funct3;
    logic       altOp;     // funct7 bit 5, picks SUB or SRA
    AluOp       arithOp;   // Operation for OP and OP_IMM

    assign opcode = Opcode'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];

    // ADDI has no SUB form, bit 30 there is immediate data
    assign altOp = i_inst[30] & ((opcode == OPC_OP) | (funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  arithOp = altOp ? ALU_SUB : ALU_ADD;
            3'b001:  arithOp = ALU_SLL;
            3'b010:  arithOp = ALU_SLT;
            3'b011:  arithOp = ALU_SLTU;
            3'b100:  arithOp = ALU_XOR;
            3'b101:  arithOp = altOp ? ALU_SRA : ALU_SRL;
            3'b110:  arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    end

    always_comb begin
        // No-op defaults
        o_ctrl.aluOp     = ALU_ADD;      // Address and link arithmetic
        o_ctrl.opASel    = OPA_RS1;
        o_ctrl.opBSel    = OPB_IMM;
        o_ctrl.wrDataSel = WR_ALU;
        o_ctrl.pcNextSel = PC_PLUS4;
        o_ctrl.regWe     = 1'b0;
        o_ctrl.memWe     = 1'b0;
        o_ctrl.memRe     = 1'b0;

        case (opcode)
            OPC_OP: begin
                o_ctrl.aluOp  = arithOp;
                o_ctrl.opBSel = OPB_RS2;
                o_ctrl.regWe  = 1'b1;
            end
            OPC_OP_IMM: begin
                o_ctrl.aluOp = arithOp;
                o_ctrl.regWe = 1'b1;
            end
            OPC_LUI: begin
                o_ctrl.aluOp  = ALU_COPY_B;
                o_ctrl.opASel = OPA_ZERO;
                o_ctrl.regWe  = 1'b1;
            end
            OPC_AUIPC: begin
                o_ctrl.opASel = OPA_PC;  // PC + upper immediate
                o_ctrl.regWe  = 1'b1;
            end
            OPC_LOAD: begin
                o_ctrl.wrDataSel = WR_MEM;
                o_ctrl.regWe     = 1'b1;
                o_ctrl.memRe     = 1'b1;
            end
            OPC_STORE:  o_ctrl.memWe = 1'b1;
            OPC_BRANCH: o_ctrl.pcNextSel = PC_BRANCH;
            OPC_JAL: begin
                o_ctrl.pcNextSel = PC_JAL;
                o_ctrl.wrDataSel = WR_PC_PLUS4;   // Link register gets PC+4
                o_ctrl.regWe     = 1'b1;
            end
            OPC_JALR: begin
                o_ctrl.pcNextSel = PC_JALR;
                o_ctrl.wrDataSel = WR_PC_PLUS4;
                o_ctrl.regWe     = 1'b1;
            end
            default: ;                   // Unknown opcode stays a no-op
        endcase
    end

endmodule

`default_nettype wire

// ==== design/GPRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module GPRegisters (
    input  logic            i_clock,
    input  logic            i_rstN,
    input  logic            i_we,      // Write enable
    input  CorePkg::GPRAddr i_waddr,
    input  CorePkg::Data    i_wdata,
    input  CorePkg::GPRAddr i_raddrA,
    input  CorePkg::GPRAddr i_raddrB,
    output CorePkg::Data    o_rdataA,
    output CorePkg::Data    o_rdataB);

    import CorePkg::*;

    Data regs [1:31];                  // x0 has no storage

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;  // Writes to x0 dropped
        end
    end

    // Combinational reads, x0 reads as zero
    assign o_rdataA = (i_raddrA == '0) ? '0 : regs[i_raddrA];
    assign o_rdataB = (i_raddrB == '0) ? '0 : regs[i_raddrB];

endmodule

`default_nettype wire

// ==== design/Alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module Alu (
    input  CorePkg::AluOp i_op,
    input  CorePkg::Data  i_dataA,
    input  CorePkg::Data  i_dataB,
    output CorePkg::Data  o_result);

    import CorePkg::*;

    logic [4:0] shamt;                 // Shift amount

    assign shamt = i_dataB[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_dataA + i_dataB;
            ALU_SUB:    o_result = i_dataA - i_dataB;
            ALU_SLL:    o_result = i_dataA << shamt;
            ALU_SLT:    o_result = Data'($signed(i_dataA) < $signed(i_dataB));
            ALU_SLTU:   o_result = Data'(i_dataA < i_dataB);
            ALU_XOR:    o_result = i_dataA ^ i_dataB;
            ALU_SRL:    o_result = i_dataA >> shamt;
            ALU_SRA:    o_result = $unsigned($signed(i_dataA) >>> shamt);  // Sign fill
            ALU_OR:     o_result = i_dataA | i_dataB;
            ALU_AND:    o_result = i_dataA & i_dataB;
            ALU_COPY_B: o_result = i_dataB;
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/BranchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module BranchUnit (
    input  CorePkg::PcNextSel i_sel,      // Next PC choice from control
    input  logic [2:0]        i_funct3,   // Branch condition
    input  CorePkg::Data      i_dataRS1,
    input  CorePkg::Data      i_dataRS2,
    input  CorePkg::InstAddr  i_pc,
    input  CorePkg::Data      i_imm,
    output CorePkg::InstAddr  o_pcNext);

    import CorePkg::*;

    logic    isEqual;
    logic    isLessSigned;
    logic    isLessUnsigned;
    logic    taken;
    InstAddr pcPlus4;
    InstAddr pcTarget;                 // Branch and JAL target
    InstAddr jalrTarget;

    assign isEqual        = i_dataRS1 == i_dataRS2;
    assign isLessSigned   = $signed(i_dataRS1) < $signed(i_dataRS2);
    assign isLessUnsigned = i_dataRS1 < i_dataRS2;

    always_comb begin
        case (i_funct3)
            3'b000:  taken = isEqual;          // BEQ
            3'b001:  taken = !isEqual;         // BNE
            3'b100:  taken = isLessSigned;     // BLT
            3'b101:  taken = !isLessSigned;    // BGE
            3'b110:  taken = isLessUnsigned;   // BLTU
            3'b111:  taken = !isLessUnsigned;  // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4    = i_pc + 32'd4;
    assign pcTarget   = i_pc + i_imm;
    assign jalrTarget = (i_dataRS1 + i_imm) & ~32'd1;  // Bit 0 cleared

    always_comb begin
        case (i_sel)
            PC_BRANCH: o_pcNext = taken ? pcTarget : pcPlus4;
            PC_JAL:    o_pcNext = pcTarget;
            PC_JALR:   o_pcNext = jalrTarget;
            default:   o_pcNext = pcPlus4;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/CoreSC.sv ====
`timescale 1ns/1ps
`default_nettype none

module CoreSC #(
    parameter int DATA_WORDS = 256)          // Data memory depth in words
(
    input  logic               i_clock,
    input  logic               i_rstN,
    input  logic               i_run,        // High runs one instruction per cycle
    input  CorePkg::Data       i_inst,       // Fetched instruction
    input  CorePkg::Data       i_memRdata,   // Data memory read value
    output CorePkg::InstAddr   o_instAddr,
    output CorePkg::DataBusReq o_dataReq,
    output CorePkg::RetireInfo o_retire);

    import CorePkg::*;

    localparam Data ADDR_MASK = Data'(DATA_WORDS * 4 - 1);  // Bytes inside data memory

    InstAddr    pc;
    InstAddr    pcNext;
    InstAddr    pcPlus4;
    DecodedInst dec;
    CtrlSignals ctrl;
    Data        rdataA;
    Data        rdataB;
    Data        operandA;
    Data        operandB;
    Data        aluResult;
    Data        loadData;
    Data        wrData;
    logic       regWe;
    logic       memWe;

    // ------------------------------
    // Program counter
    // ------------------------------

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            pc <= '0;
        else if (i_run)
            pc <= pcNext;                    // Holds while paused
    end

    assign pcPlus4    = pc + 32'd4;
    assign o_instAddr = pc;

    // ------------------------------
    // Decode and control
    // ------------------------------

    InstDecoder
    dec0 (
        .i_inst (i_inst),
        .o_dec  (dec));

    DatapathController
    dpCtrl (
        .i_inst (i_inst),
        .o_ctrl (ctrl));

    assign regWe = ctrl.regWe & i_run;
    assign memWe = ctrl.memWe & i_run;

    GPRegisters
    gpr (
        .i_clock  (i_clock),
        .i_rstN   (i_rstN),
        .i_we     (regWe),
        .i_waddr  (dec.rd),
        .i_wdata  (wrData),
        .i_raddrA (dec.rs1),
        .i_raddrB (dec.rs2),
        .o_rdataA (rdataA),
        .o_rdataB (rdataB));

    // ------------------------------
    // Execute
    // ------------------------------

    always_comb begin
        case (ctrl.opASel)
            OPA_PC:   operandA = pc;         // AUIPC
            OPA_ZERO: operandA = '0;
            default:  operandA = rdataA;
        endcase
    end

    assign operandB = (ctrl.opBSel == OPB_IMM) ? dec.imm : rdataB;

    Alu
    alu (
        .i_op     (ctrl.aluOp),
        .i_dataA  (operandA),
        .i_dataB  (operandB),
        .o_result (aluResult));

    BranchUnit
    brUnit (
        .i_sel     (ctrl.pcNextSel),
        .i_funct3  (dec.funct3),
        .i_dataRS1 (rdataA),
        .i_dataRS2 (rdataB),
        .i_pc      (pc),
        .i_imm     (dec.imm),
        .o_pcNext  (pcNext));

    // ------------------------------
    // Writeback and data bus
    // ------------------------------

    assign loadData = ctrl.memRe ? i_memRdata : '0;

    always_comb begin
        case (ctrl.wrDataSel)
            WR_MEM:      wrData = loadData;
            WR_PC_PLUS4: wrData = pcPlus4;   // Link address
            default:     wrData = aluResult;
        endcase
    end

    assign o_dataReq.addr  = aluResult & ADDR_MASK;
    assign o_dataReq.we    = memWe;
    assign o_dataReq.wdata = rdataB;         // Store data from rs2

    // Record of the instruction committing at the next edge
    always_comb begin
        o_retire.valid   = i_run;
        o_retire.pc      = pc;
        o_retire.inst    = i_inst;
        o_retire.regWe   = regWe;
        o_retire.rd      = dec.rd;
        o_retire.regData = wrData;
        o_retire.memWe   = memWe;
        o_retire.memAddr = aluResult;        // Full architectural address
        o_retire.memData = rdataB;
    end

endmodule

`default_nettype wire

// ==== design/InstMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module InstMemory #(
    parameter int INST_WORDS = 256)            // Depth in words
(
    input  logic                          i_clock,
    input  logic                          i_run,       // Load blocked while high
    input  logic                          i_loadEn,
    input  logic [$clog2(INST_WORDS)-1:0] i_loadAddr,  // Word index
    input  CorePkg::Data                  i_loadData,
    input  CorePkg::InstAddr              i_addr,      // Byte address from the PC
    output CorePkg::Data                  o_inst);

    import CorePkg::*;

    localparam int IDX_BITS = $clog2(INST_WORDS);

    Data mem [INST_WORDS];                     // Program storage

    always_ff @(posedge i_clock) begin
        if (i_loadEn && !i_run)
            mem[i_loadAddr] <= i_loadData;
    end

    // Zero latency fetch, index wraps at the depth
    assign o_inst = mem[i_addr[IDX_BITS+1:2]];

endmodule

`default_nettype wire

// ==== design/DataMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module DataMemory #(
    parameter int DATA_WORDS = 256)            // Depth in words
(
    input  logic               i_clock,
    input  CorePkg::DataBusReq i_req,          // Address, enable and write data
    output CorePkg::Data       o_rdata);

    import CorePkg::*;

    localparam int IDX_BITS = $clog2(DATA_WORDS);

    Data                mem [DATA_WORDS];
    logic [IDX_BITS-1:0] index;                // Word index modulo depth

    assign index = i_req.addr[IDX_BITS+1:2];

    // Synchronous word write
    always_ff @(posedge i_clock) begin
        if (i_req.we)
            mem[index] <= i_req.wdata;
    end

    assign o_rdata = mem[index];               // Combinational read

endmodule

`default_nettype wire

// ==== design/Processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module Processor #(
    parameter int INST_WORDS = 256,
    parameter int DATA_WORDS = 256)
(
    input  logic                          i_clock,
    input  logic                          i_rstN,
    input  logic                          i_run,       // Low pauses and allows loading
    input  logic                          i_loadEn,
    input  logic [$clog2(INST_WORDS)-1:0] i_loadAddr,  // Instruction word index
    input  CorePkg::Data                  i_loadData,
    output CorePkg::RetireInfo            o_retire);

    import CorePkg::*;

    InstAddr   instAddr;
    Data       inst;
    DataBusReq dataReq;
    Data       memRdata;

    // ------------------------------
    // Core and memories
    // ------------------------------

    CoreSC #(
        .DATA_WORDS (DATA_WORDS))
    core (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_run      (i_run),
        .i_inst     (inst),
        .i_memRdata (memRdata),
        .o_instAddr (instAddr),
        .o_dataReq  (dataReq),
        .o_retire   (o_retire));

    InstMemory #(
        .INST_WORDS (INST_WORDS))
    instMem (
        .i_clock    (i_clock),
        .i_run      (i_run),
        .i_loadEn   (i_loadEn),
        .i_loadAddr (i_loadAddr),
        .i_loadData (i_loadData),
        .i_addr     (instAddr),
        .o_inst     (inst));

    DataMemory #(
        .DATA_WORDS (DATA_WORDS))
    dataMem (
        .i_clock (i_clock),
        .i_req   (dataReq),
        .o_rdata (memRdata));

endmodule

`default_nettype wire

// ==== bench/ProcessorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ProcessorTb;

    import CorePkg::*;

    logic       clock;
    logic       rstN;
    logic       run;
    logic       loadEn;
    logic [7:0] loadAddr;                  // Word index into 256 words
    Data        loadData;
    RetireInfo  retire;

    // Reference ISA state
    Data     mReg  [32];
    Data     mMem  [256];
    Data     mImem [256];                  // Mirror of loaded program
    InstAddr mPc;
    Data     prog [$];                     // Program being assembled

    int checks;
    int errors;
    int timeouts;
    int retired;

    Processor
    DUT (
        .i_clock    (clock),
        .i_rstN     (rstN),
        .i_run      (run),
        .i_loadEn   (loadEn),
        .i_loadAddr (loadAddr),
        .i_loadData (loadData),
        .o_retire   (retire));

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;        // 40 ns period
    end

    // ------------------------------
    // Encoders
    // ------------------------------

    function automatic Data rType(input logic [6:0] f7, input GPRAddr rs2, input GPRAddr rs1,
                                  input logic [2:0] f3, input GPRAddr rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic Data iType(input logic [11:0] imm, input GPRAddr rs1,
                                  input logic [2:0] f3, input GPRAddr rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic Data sType(input logic [11:0] imm, input GPRAddr rs2, input GPRAddr rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // SW only
    endfunction

    function automatic Data bType(input logic [12:0] off, input GPRAddr rs2, input GPRAddr rs1,
                                  input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic Data uType(input logic [19:0] imm, input GPRAddr rd,
                                  input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic Data jType(input logic [20:0] off, input GPRAddr rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic Data addi(input GPRAddr rd, input GPRAddr rs1, input logic [11:0] imm);
        return iType(imm, rs1, 3'b000, rd, OPC_OP_IMM);
    endfunction

    function automatic void emit(input Data word);
        prog.push_back(word);
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic RetireInfo refStep(input Data inst);
        RetireInfo  r;
        logic [6:0] opc;
        logic [2:0] f3;
        GPRAddr     rd;
        Data        a;
        Data        b;
        Data        opB;
        Data        immI;
        Data        immS;
        Data        immB;
        Data        immU;
        Data        immJ;
        Data        addr;
        Data        val;
        InstAddr    nextPc;
        logic       lts;
        logic       taken;
        opc  = inst[6:0];
        f3   = inst[14:12];
        rd   = inst[11:7];
        a    = mReg[inst[19:15]];
        b    = mReg[inst[24:20]];
        immI = {{20{inst[31]}}, inst[31:20]};
        immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        immU = {inst[31:12], 12'h000};
        immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = mPc;
        r.inst    = inst;
        r.rd      = rd;
        nextPc    = mPc + 32'd4;
        val       = '0;
        lts       = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // Signed via bias
        case (opc)
            OPC_LUI: begin
                r.regWe = 1'b1;
                val     = immU;
            end
            OPC_AUIPC: begin
                r.regWe = 1'b1;
                val     = mPc + immU;
            end
            OPC_OP, OPC_OP_IMM: begin
                r.regWe = 1'b1;
                opB     = (opc == OPC_OP) ? b : immI;
                case (f3)
                    3'b000:  val = ((opc == OPC_OP) && inst[30]) ? a - opB : a + opB;  // SUB
                    3'b001:  val = a << opB[4:0];
                    3'b010:  val = {31'b0, (a ^ 32'h8000_0000) < (opB ^ 32'h8000_0000)};
                    3'b011:  val = {31'b0, a < opB};
                    3'b100:  val = a ^ opB;
                    3'b101:  val = (a >> opB[4:0]) |
                                   ((inst[30] && a[31]) ? ~(32'hFFFF_FFFF >> opB[4:0]) : 32'd0);
                    3'b110:  val = a | opB;
                    default: val = a & opB;
                endcase
            end
            OPC_LOAD: begin
                addr      = a + immI;
                r.regWe   = 1'b1;
                r.memAddr = addr;
                val       = mMem[addr[9:2]];  // Word index wraps at 256
            end
            OPC_STORE: begin
                addr              = a + immS;
                r.memWe           = 1'b1;
                r.memAddr         = addr;
                r.memData         = b;
                mMem[addr[9:2]]   = b;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = lts;
                    3'b101:  taken = !lts;
                    3'b110:  taken = a < b;
                    3'b111:  taken = !(a < b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    nextPc = mPc + immB;
            end
            OPC_JAL: begin
                r.regWe = 1'b1;
                val     = mPc + 32'd4;       // Link
                nextPc  = mPc + immJ;
            end
            OPC_JALR: begin
                r.regWe = 1'b1;
                val     = mPc + 32'd4;
                nextPc  = (a + immI) & ~32'd1;
            end
            default: ;                       // Unknown word has no effect
        endcase
        r.regData = val;
        if (r.regWe && (rd != 5'd0))
            mReg[rd] = val;                  // x0 never changes
        mPc = nextPc;
        return r;
    endfunction

    // ------------------------------
    // Checking
    // ------------------------------

    task automatic checkEq(input Data actual, input Data expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Sampled mid-cycle before the record commits at the next rising edge
    always @(negedge clock) begin
        RetireInfo want;
        checkEq(Data'(retire.valid), Data'(run), "valid");   // No retire while paused
        if (run) begin
            if (retired == 0)
                checkEq(retire.pc, 32'd0, "first pc");
            want = refStep(mImem[mPc[9:2]]);
            checkEq(retire.pc, want.pc, "pc");
            checkEq(retire.inst, want.inst, "inst");
            checkEq(Data'(retire.regWe), Data'(want.regWe), "regWe");
            checkEq(Data'(retire.rd), Data'(want.rd), "rd");
            if (want.regWe)
                checkEq(retire.regData, want.regData, "regData");
            checkEq(Data'(retire.memWe), Data'(want.memWe), "memWe");
            if (want.memWe || (want.inst[6:0] == OPC_LOAD))
                checkEq(retire.memAddr, want.memAddr, "memAddr");
            if (want.memWe)
                checkEq(retire.memData, want.memData, "memData");
            retired++;
        end
    end

    // ------------------------------
    // Load and run
    // ------------------------------

    task automatic patchWord(input logic [7:0] index, input Data word);
        @(posedge clock);
        loadEn   <= 1'b1;
        loadAddr <= index;
        loadData <= word;
        mImem[index] = word;                 // Model copy
        @(posedge clock);
        loadEn <= 1'b0;
    endtask

    // Places the assembled program at the current PC
    task automatic loadProgram(output InstAddr endPc);
        logic [7:0] base;
        base = mPc[9:2];
        foreach (prog[i])
            patchWord(base + 8'(i), prog[i]);
        endPc = mPc + InstAddr'(prog.size() * 4);
        prog.delete();
    endtask

    task automatic runUntil(input InstAddr stopPc, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clock);
        run <= 1'b1;
        do begin
            @(posedge clock);
            cycles++;
        end while ((mPc != stopPc) && (cycles < limit));
        run <= 1'b0;                         // Last instruction committed at this edge
        if (mPc != stopPc) begin
            timeouts++;
            $display("Timeout: pc %h did not reach %h in %0d cycles", mPc, stopPc, limit);
        end
    endtask

    // ------------------------------
    // Programs
    // ------------------------------

    // Every data word gets its own byte address
    task automatic fillDataMemory();
        InstAddr endPc;
        emit(addi(5'd1, 5'd0, 12'd0));
        emit(addi(5'd2, 5'd0, 12'd1024));    // 256 words
        emit(sType(12'd0, 5'd1, 5'd1));
        emit(addi(5'd1, 5'd1, 12'd4));
        emit(bType(13'h1FF8, 5'd2, 5'd1, 3'b001));  // BNE back to SW
        loadProgram(endPc);
        runUntil(endPc, 1000);
    endtask

    task automatic aluRandom();
        InstAddr endPc;
        Data     r;
        Data     s;
        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            s = $urandom;
            case (r[31:30])
                2'd0:    emit(uType(s[31:12], r[4:0], OPC_LUI));
                2'd1:    emit(addi(r[4:0], r[9:5], s[11:0]));
                default: emit(rType(((r[17:15] == 3'b000) || (r[17:15] == 3'b101)) && r[18]
                                    ? 7'b0100000 : 7'b0000000,
                                    r[14:10], r[9:5], r[17:15], r[4:0]));
            endcase
        end
        emit(addi(5'd0, 5'd7, 12'd55));      // Write to x0 is dropped
        emit(rType(7'd0, 5'd0, 5'd0, 3'b000, 5'd9));  // x9 = x0 + x0
        loadProgram(endPc);
        runUntil(endPc, 200);
    endtask

    task automatic loadStoreTest();
        logic [11:0] offs [8];
        logic [11:0] off;
        logic        hit;
        int          tries;
        Data         r;
        InstAddr     endPc;
        r = $urandom;
        emit(uType(r[31:12], 5'd10, OPC_LUI));   // Base with low 12 bits zero
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            offs[i] = {r[11:2], 2'b00};
            r = $urandom;
            emit(uType(r[31:12], 5'd11, OPC_LUI));
            emit(addi(5'd11, 5'd11, r[11:0]));
            emit(sType(offs[i], 5'd11, 5'd10));
        end
        for (int i = 0; i < 8; i++)
            emit(iType(offs[i], 5'd10, 3'b010, 5'd12, OPC_LOAD));
        // Reads of words that no store touched
        for (int k = 0; k < 4; k++) begin
            tries = 0;
            do begin
                r   = $urandom;
                off = {r[11:2], 2'b00};
                hit = 1'b0;
                for (int j = 0; j < 8; j++)
                    if (off[9:2] == offs[j][9:2])
                        hit = 1'b1;
                tries++;
            end while (hit && (tries < 20));
            emit(iType(off, 5'd10, 3'b010, 5'd13, OPC_LOAD));
        end
        loadProgram(endPc);
        runUntil(endPc, 200);
    endtask

    // Taken branch skips its marker and the other falls into it
    task automatic branchPair(input logic [2:0] f3, input GPRAddr tRs1, input GPRAddr tRs2,
                              input GPRAddr nRs1, input GPRAddr nRs2);
        emit(bType(13'd8, tRs2, tRs1, f3));
        emit(addi(5'd30, 5'd30, 12'd1));
        emit(bType(13'd8, nRs2, nRs1, f3));
        emit(addi(5'd30, 5'd30, 12'd1));
    endtask

    task automatic controlFlowTest();
        InstAddr endPc;
        emit(addi(5'd20, 5'd0, 12'hFFB));    // -5
        emit(addi(5'd21, 5'd0, 12'd7));
        emit(addi(5'd22, 5'd0, 12'd7));
        emit(addi(5'd30, 5'd0, 12'd0));
        branchPair(3'b000, 5'd21, 5'd22, 5'd20, 5'd21);  // BEQ
        branchPair(3'b001, 5'd20, 5'd21, 5'd21, 5'd22);  // BNE
        branchPair(3'b100, 5'd20, 5'd21, 5'd21, 5'd20);  // BLT
        branchPair(3'b101, 5'd21, 5'd20, 5'd20, 5'd21);  // BGE
        branchPair(3'b110, 5'd21, 5'd20, 5'd20, 5'd21);  // BLTU sees -5 as large
        branchPair(3'b111, 5'd20, 5'd21, 5'd21, 5'd20);  // BGEU
        emit(jType(21'd8, 5'd1));            // JAL over one word
        emit(addi(5'd31, 5'd0, 12'd1));
        emit(uType(20'd0, 5'd5, OPC_AUIPC));
        emit(iType(12'd13, 5'd5, 3'b000, 5'd6, OPC_JALR));  // Odd target loses bit 0
        emit(addi(5'd31, 5'd0, 12'd2));
        emit(rType(7'd0, 5'd0, 5'd1, 3'b000, 5'd7));   // Read back both links
        emit(rType(7'd0, 5'd0, 5'd6, 3'b000, 5'd8));
        loadProgram(endPc);
        runUntil(endPc, 200);
    endtask

    task automatic pauseTest();
        InstAddr startPc;
        InstAddr endPc;
        int      pauseCycles;
        Data     r;
        startPc = mPc;
        for (int i = 0; i < 8; i++)
            emit(addi(5'd15, 5'd15, 12'd3));
        loadProgram(endPc);
        runUntil(startPc + 32'd8, 50);       // Stop after two words
        pauseCycles = 2 + $urandom % 8;
        for (int i = 0; i < pauseCycles; i++)
            @(posedge clock);
        r = $urandom;
        patchWord(startPc[9:2] + 8'd5, uType(r[31:12], 5'd16, OPC_LUI));  // Not reached yet
        runUntil(endPc, 50);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        void'($urandom(45));                 // Fixed seed
        rstN     = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        retired  = 0;
        mPc      = '0;
        for (int i = 0; i < 32; i++)
            mReg[i] = '0;
        for (int i = 0; i < 256; i++) begin
            mMem[i]  = '0;
            mImem[i] = '0;
        end
        repeat (8) @(posedge clock);
        rstN <= 1'b1;
        repeat (3) @(posedge clock);         // Idle with valid held low

        fillDataMemory();
        aluRandom();
        loadStoreTest();
        controlFlowTest();
        pauseTest();

        repeat (2) @(posedge clock);
        $display("Retired %0d, checks %0d, errors %0d, timeouts %0d",
                 retired, checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0) && (retired > 0))
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/CorePkg.sv
design/InstDecoder.sv
design/DatapathController.sv
design/GPRegisters.sv
design/Alu.sv
design/BranchUnit.sv
design/CoreSC.sv
design/InstMemory.sv
design/DataMemory.sv
design/Processor.sv
bench/ProcessorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; success only if the pass line appears

cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module ProcessorTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -Fqx '** PASS **' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
